// ==== include/msi_config.svh ====
// MSI controller configuration
`ifndef MSI_CONFIG_SVH
`define MSI_CONFIG_SVH

// ============================================================
// queues and message format
// ============================================================
`define MSI_NQUES       7       // priorities 1..7, priority 0 is ignored
`define MSI_QDEPTH      8       // entries per priority queue
`define MSI_MSG_W       16      // message word width
`define MSI_VEC_IDX_W   10      // {om, vecno} table index
`define MSI_FAIR_PERIOD 8       // every eighth grant goes to the lowest queue

// ============================================================
// vector table entry layout
// ============================================================
`define MSI_ENT_W        32
`define MSI_ENT_IE       31     // entry enable
`define MSI_ENT_SWSTK_HI 30     // stack selector
`define MSI_ENT_SWSTK_LO 28
`define MSI_ENT_HND_HI   27     // handler address, in 16 byte units
`define MSI_ENT_HND_LO   0

// register map, word addresses
`define MSI_ADDR_W      12
`define MSI_REG_CTRL    12'h000 // [0] global enable, [3:1] threshold
`define MSI_REG_STAT    12'h001 // [0] sticky queue full, [7:1] queue empty
`define MSI_REG_EN_BASE 12'h020 // 32 enable words
`define MSI_REG_VT_BASE 12'h400 // 1024 table entries

`endif

// ==== hdl/msi_pkg.sv ====
// MSI controller types
package msi_pkg;

	// one message word, read two ways
	//   fld : priority, mode bank and vector number for the table lookup
	//   en  : the same index split into enable-array word and bit
	typedef union packed {
		struct packed {
			logic [2:0] pri;        // queue select, 0 = dropped
			logic [1:0] om;         // mode bank of the vector table
			logic [7:0] vecno;      // vector within the bank
			logic [2:0] resv;
		} fld;
		struct packed {
			logic [2:0] pri;
			logic [4:0] en_word;    // enable word, same bits as om + vecno[7:5]
			logic [4:0] en_bit;     // bit within that word
			logic [2:0] resv;
		} en;
	} msi_msg_u;

	// {om, vecno} and {en_word, en_bit} cover the same ten bits,
	// so one lookup index serves both the table and the enable array

endpackage

// ==== hdl/msi_fifo.sv ====
// Priority queue FIFO
`timescale 1ns/1ps

module msi_fifo #(
	parameter int DEPTH = 8,
	parameter int WIDTH = 16
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             wr_en_i,
	input  logic [WIDTH-1:0] din_i,
	input  logic             rd_en_i,
	output logic [WIDTH-1:0] dout_o,    // head of queue, show-ahead
	output logic             empty_o,
	output logic             ovf_o      // write attempted while full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [CW-1:0]    count;          // entries held
	logic             full;
	logic             do_wr;
	logic             do_rd;

	assign full    = count == CW'(DEPTH);
	assign empty_o = count == '0;
	assign do_wr   = wr_en_i && !full;  // full queue drops the message
	assign do_rd   = rd_en_i && !empty_o;
	assign ovf_o   = wr_en_i && full;   // one cycle per dropped message
	assign dout_o  = mem[rd_ptr];

	// storage
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din_i;
	end

	// pointers and fill count
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;        // idle or read and write together
			endcase
		end
	end

	// the arbiter must only pop a queue that holds something
	a_no_underflow: assert property (@(posedge clk) disable iff (rst)
		rd_en_i |-> !empty_o);

endmodule

// ==== hdl/msi_prio_arb.sv ====
// Priority queues and arbiter
`timescale 1ns/1ps
`include "msi_config.svh"

module msi_prio_arb (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   msg_valid_i,
	input  msi_pkg::msi_msg_u      msg_i,
	input  logic [2:0]             threshold_i,
	input  logic                   gnt_ready_i,
	output logic                   gnt_valid_o,
	output msi_pkg::msi_msg_u      gnt_msg_o,
	output logic [`MSI_NQUES-1:0]  q_empty_o,  // bit n is priority n+1
	output logic                   q_ovf_o
);

	msi_pkg::msi_msg_u     q_dout [`MSI_NQUES];  // queue heads
	logic [`MSI_NQUES-1:0] q_wr;
	logic [`MSI_NQUES-1:0] q_rd;
	logic [`MSI_NQUES-1:0] q_ovf;
	logic [`MSI_NQUES-1:0] elig;                 // non-empty and above threshold
	logic [2:0]            sel;                  // queue being offered
	logic [2:0]            gcnt;                 // grants since last fair turn
	logic                  fair;
	logic                  pop;

	// ============================================================
	// one queue per priority 1..7
	// ============================================================
	for (genvar g = 0; g < `MSI_NQUES; g++) begin : g_que
		assign q_wr[g] = msg_valid_i && (msg_i.fld.pri == 3'(g + 1)); // pri 0 matches none
		assign q_rd[g] = pop && (sel == 3'(g));

		msi_fifo #(
			.DEPTH (`MSI_QDEPTH),
			.WIDTH (`MSI_MSG_W)
		) i_fifo (
			.clk     (clk),
			.rst     (rst),
			.wr_en_i (q_wr[g]),
			.din_i   (msg_i),
			.rd_en_i (q_rd[g]),
			.dout_o  (q_dout[g]),
			.empty_o (q_empty_o[g]),
			.ovf_o   (q_ovf[g])
		);

		// priority 7 ignores the threshold
		assign elig[g] = !q_empty_o[g] &&
			((3'(g + 1) > threshold_i) || (g + 1 == `MSI_NQUES));
	end

	assign q_ovf_o = |q_ovf;

	// ============================================================
	// selection
	// ============================================================
	assign fair = gcnt == 3'(`MSI_FAIR_PERIOD - 1);

	// last match wins, so the loop direction picks highest or lowest
	always_comb begin
		sel = 3'd0;
		if (fair) begin
			for (int i = `MSI_NQUES - 1; i >= 0; i--)
				if (elig[i])
					sel = 3'(i);
		end else begin
			for (int i = 0; i < `MSI_NQUES; i++)
				if (elig[i])
					sel = 3'(i);
		end
	end

	assign gnt_valid_o = |elig;
	assign gnt_msg_o   = q_dout[sel];
	assign pop         = gnt_valid_o && gnt_ready_i;

	// the grant counter advances on every pop including discarded ones
	always_ff @(posedge clk) begin
		if (rst)
			gcnt <= 3'd0;
		else if (pop)
			gcnt <= gcnt + 3'd1;    // wraps to 0 right after the fair turn
	end

	// offered head must come from a live queue and carry that queue's priority
	a_gnt_queue: assert property (@(posedge clk) disable iff (rst)
		gnt_valid_o |-> (!q_empty_o[sel] && gnt_msg_o.fld.pri == sel + 3'd1));

endmodule

// ==== hdl/msi_vec_table.sv ====
// Vector table RAM
`timescale 1ns/1ps
`include "msi_config.svh"

module msi_vec_table (
	input  logic                      clk,
	// register side port
	input  logic                      wr_en_i,
	input  logic                      rd_en_i,
	input  logic [`MSI_VEC_IDX_W-1:0] addr_i,
	input  logic [`MSI_ENT_W-1:0]     wdata_i,
	output logic [`MSI_ENT_W-1:0]     rdata_o,
	// dispatcher lookup port, read only
	input  logic [`MSI_VEC_IDX_W-1:0] lu_idx_i,
	output logic [`MSI_ENT_W-1:0]     lu_entry_o
);

	localparam int NENT = 1 << `MSI_VEC_IDX_W;  // four banks of 256 vectors

	// contents are undefined until software fills them
	logic [`MSI_ENT_W-1:0] mem [NENT];

	// port A, register writes and reads
	always_ff @(posedge clk) begin
		if (wr_en_i)
			mem[addr_i] <= wdata_i;
		if (rd_en_i)
			rdata_o <= mem[addr_i];     // held until the next read
	end

	// port B, lookup every cycle
	// the dispatcher picks the cycle it needs
	always_ff @(posedge clk) begin
		lu_entry_o <= mem[lu_idx_i];
	end

endmodule

// ==== hdl/msi_regs.sv ====
// Control and status registers
`timescale 1ns/1ps
`include "msi_config.svh"

module msi_regs (
	input  logic                      clk,
	input  logic                      rst,
	// register port
	input  logic                      reg_we_i,
	input  logic                      reg_re_i,
	input  logic [`MSI_ADDR_W-1:0]    reg_addr_i,
	input  logic [31:0]               reg_wdata_i,
	output logic [31:0]               reg_rdata_o,
	output logic                      reg_rvalid_o,
	// arbiter status
	input  logic [`MSI_NQUES-1:0]     q_empty_i,
	input  logic                      q_ovf_i,
	// control out
	output logic                      global_en_o,
	output logic [2:0]                threshold_o,
	// per-vector enable lookup
	input  logic [`MSI_VEC_IDX_W-1:0] lu_idx_i,
	output logic                      lu_en_o,
	// vector table access
	output logic                      vt_wr_o,
	output logic                      vt_rd_o,
	output logic [`MSI_VEC_IDX_W-1:0] vt_addr_o,
	output logic [`MSI_ENT_W-1:0]     vt_wdata_o,
	input  logic [`MSI_ENT_W-1:0]     vt_rdata_i
);

	logic [31:0]       en_arr [32];   // one bit per vector, 1024 total
	logic              ovf_flag;      // sticky queue full
	logic              sel_ctrl;
	logic              sel_stat;
	logic              sel_en;
	logic              sel_vt;
	logic              rd_vt_q;       // last read went to the table
	logic [31:0]       loc_rdata_q;   // last local register read
	msi_pkg::msi_msg_u lu_msg;

	// ============================================================
	// address decode
	// ============================================================
	assign sel_ctrl = reg_addr_i == `MSI_REG_CTRL;
	assign sel_stat = reg_addr_i == `MSI_REG_STAT;
	assign sel_en   = (reg_addr_i & 12'hFE0) == `MSI_REG_EN_BASE;  // 0x020..0x03F
	assign sel_vt   = (reg_addr_i & 12'hC00) == `MSI_REG_VT_BASE;  // 0x400..0x7FF

	// table accesses pass straight through
	assign vt_wr_o    = reg_we_i && sel_vt;
	assign vt_rd_o    = reg_re_i && sel_vt;
	assign vt_addr_o  = reg_addr_i[`MSI_VEC_IDX_W-1:0];
	assign vt_wdata_o = reg_wdata_i;

	// writes take effect at the sampling edge
	always_ff @(posedge clk) begin
		if (rst) begin
			global_en_o <= 1'b0;
			threshold_o <= 3'd0;
			ovf_flag    <= 1'b0;
			for (int i = 0; i < 32; i++)
				en_arr[i] <= '0;
		end else begin
			if (reg_we_i && sel_ctrl) begin
				global_en_o <= reg_wdata_i[0];
				threshold_o <= reg_wdata_i[3:1];
			end
			if (reg_we_i && sel_stat && !reg_wdata_i[0])
				ovf_flag <= 1'b0;           // write 0 to clear
			if (q_ovf_i)
				ovf_flag <= 1'b1;           // a new drop beats the clear
			if (reg_we_i && sel_en)
				en_arr[reg_addr_i[4:0]] <= reg_wdata_i;
		end
	end

	// ============================================================
	// read path, data valid one cycle after reg_re_i
	// ============================================================
	always_ff @(posedge clk) begin
		if (rst)
			reg_rvalid_o <= 1'b0;
		else
			reg_rvalid_o <= reg_re_i;
	end

	always_ff @(posedge clk) begin
		if (reg_re_i) begin
			rd_vt_q <= sel_vt;
			if (sel_ctrl)
				loc_rdata_q <= {28'd0, threshold_o, global_en_o};
			else if (sel_stat)
				loc_rdata_q <= {{(31 - `MSI_NQUES){1'b0}}, q_empty_i, ovf_flag};
			else if (sel_en)
				loc_rdata_q <= en_arr[reg_addr_i[4:0]];
			else
				loc_rdata_q <= 32'd0;       // unmapped reads as zero
		end
	end

	// table data comes from the RAM output register in the same cycle
	assign reg_rdata_o = rd_vt_q ? vt_rdata_i : loc_rdata_q;

	// enable bit for the dispatcher, index split as word and bit
	assign lu_msg = {3'b000, lu_idx_i, 3'b000};

	always_ff @(posedge clk) begin
		lu_en_o <= en_arr[lu_msg.en.en_word][lu_msg.en.en_bit];
	end

endmodule

// ==== hdl/msi_dispatch.sv ====
// Interrupt dispatcher
`timescale 1ns/1ps
`include "msi_config.svh"

module msi_dispatch (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      gnt_valid_i,
	input  msi_pkg::msi_msg_u         gnt_msg_i,
	output logic                      gnt_ready_o,
	output logic [`MSI_VEC_IDX_W-1:0] lu_idx_o,
	input  logic [`MSI_ENT_W-1:0]     lu_entry_i,   // one cycle after lu_idx_o
	input  logic                      lu_en_i,      // one cycle after lu_idx_o
	input  logic                      global_en_i,
	input  logic                      irq_ack_i,
	output logic                      irq_o,
	output logic [31:0]               ivect_o,
	output logic [2:0]                ipri_o,
	output logic [2:0]                swstk_o
);

	localparam logic [1:0] S_IDLE   = 2'd0;  // waiting for a grant
	localparam logic [1:0] S_LOOKUP = 2'd1;  // table entry and enable bit arrive
	localparam logic [1:0] S_HOLD   = 2'd2;  // irq_o up until acknowledge

	logic [1:0]        state;
	msi_pkg::msi_msg_u msg_q;               // accepted message
	logic              take;
	logic              entry_ok;

	assign gnt_ready_o = state == S_IDLE;
	assign take        = gnt_valid_i && gnt_ready_o;  // pop in the arbiter
	assign irq_o       = state == S_HOLD;

	// in idle the offered message drives the lookup so the RAM samples it
	// on the pop edge; after that the captured copy holds the index
	assign lu_idx_o = (state == S_IDLE) ? {gnt_msg_i.fld.om, gnt_msg_i.fld.vecno}
	                                    : {msg_q.fld.om, msg_q.fld.vecno};

	// all three enables needed
	assign entry_ok = lu_entry_i[`MSI_ENT_IE] && global_en_i && lu_en_i;

	// ============================================================
	// state machine
	// ============================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE:   if (take) state <= S_LOOKUP;
				S_LOOKUP: state <= entry_ok ? S_HOLD : S_IDLE;  // disabled, discard
				S_HOLD:   if (irq_ack_i) state <= S_IDLE;
				default:  state <= S_IDLE;
			endcase
		end
	end

	// message capture and interrupt outputs
	always_ff @(posedge clk) begin
		if (take)
			msg_q <= gnt_msg_i;
		if (state == S_LOOKUP) begin
			ivect_o <= {lu_entry_i[`MSI_ENT_HND_HI:`MSI_ENT_HND_LO], 4'h0};  // 16 byte aligned
			ipri_o  <= msg_q.fld.pri;
			swstk_o <= lu_entry_i[`MSI_ENT_SWSTK_HI:`MSI_ENT_SWSTK_LO];
		end
	end

	// the CPU sees one steady request until it acknowledges
	a_hold_stable: assert property (@(posedge clk) disable iff (rst)
		(irq_o && !irq_ack_i) |=>
		(irq_o && $stable(ivect_o) && $stable(ipri_o) && $stable(swstk_o)));

endmodule

// ==== hdl/msi_top.sv ====
// MSI controller top level
`timescale 1ns/1ps
`include "msi_config.svh"

module msi_top (
	input  logic                   clk,
	input  logic                   rst,
	// message strobe
	input  logic                   msg_valid_i,
	input  msi_pkg::msi_msg_u      msg_i,
	// register port
	input  logic                   reg_we_i,
	input  logic                   reg_re_i,
	input  logic [`MSI_ADDR_W-1:0] reg_addr_i,
	input  logic [31:0]            reg_wdata_i,
	output logic [31:0]            reg_rdata_o,
	output logic                   reg_rvalid_o,
	// CPU side
	output logic                   irq_o,
	output logic [31:0]            ivect_o,
	output logic [2:0]             ipri_o,
	output logic [2:0]             swstk_o,
	input  logic                   irq_ack_i
);

	logic                      global_en;
	logic [2:0]                threshold;
	logic                      gnt_valid;
	logic                      gnt_ready;
	msi_pkg::msi_msg_u         gnt_msg;
	logic [`MSI_NQUES-1:0]     q_empty;
	logic                      q_ovf;
	logic [`MSI_VEC_IDX_W-1:0] lu_idx;
	logic [`MSI_ENT_W-1:0]     lu_entry;
	logic                      lu_en;
	logic                      vt_wr;
	logic                      vt_rd;
	logic [`MSI_VEC_IDX_W-1:0] vt_addr;
	logic [`MSI_ENT_W-1:0]     vt_wdata;
	logic [`MSI_ENT_W-1:0]     vt_rdata;

	msi_regs i_regs (
		.clk (clk), .rst (rst),
		.reg_we_i (reg_we_i), .reg_re_i (reg_re_i),
		.reg_addr_i (reg_addr_i), .reg_wdata_i (reg_wdata_i),
		.reg_rdata_o (reg_rdata_o), .reg_rvalid_o (reg_rvalid_o),
		.q_empty_i (q_empty), .q_ovf_i (q_ovf),
		.global_en_o (global_en), .threshold_o (threshold),
		.lu_idx_i (lu_idx), .lu_en_o (lu_en),
		.vt_wr_o (vt_wr), .vt_rd_o (vt_rd), .vt_addr_o (vt_addr),
		.vt_wdata_o (vt_wdata), .vt_rdata_i (vt_rdata)
	);

	msi_prio_arb i_arb (
		.clk (clk), .rst (rst),
		.msg_valid_i (msg_valid_i), .msg_i (msg_i), .threshold_i (threshold),
		.gnt_ready_i (gnt_ready), .gnt_valid_o (gnt_valid), .gnt_msg_o (gnt_msg),
		.q_empty_o (q_empty), .q_ovf_o (q_ovf)
	);

	msi_vec_table i_vtab (
		.clk (clk), .wr_en_i (vt_wr), .rd_en_i (vt_rd), .addr_i (vt_addr),
		.wdata_i (vt_wdata), .rdata_o (vt_rdata),
		.lu_idx_i (lu_idx), .lu_entry_o (lu_entry)
	);

	msi_dispatch i_disp (
		.clk (clk), .rst (rst),
		.gnt_valid_i (gnt_valid), .gnt_msg_i (gnt_msg), .gnt_ready_o (gnt_ready),
		.lu_idx_o (lu_idx), .lu_entry_i (lu_entry), .lu_en_i (lu_en),
		.global_en_i (global_en), .irq_ack_i (irq_ack_i),
		.irq_o (irq_o), .ivect_o (ivect_o), .ipri_o (ipri_o), .swstk_o (swstk_o)
	);

endmodule

// ==== verification/msi_tb.sv ====
// MSI controller testbench
`timescale 1ns/1ps
`include "msi_config.svh"

module msi_tb;

	localparam int N_MSG     = 46;                      // messages sent over the run
	localparam int SETUP_CYC = 1500;                    // table fill, enables, register reads
	localparam int LIMIT_CYC = SETUP_CYC + N_MSG * 20;

	logic        clk = 1'b0;
	logic        rst = 1'b1;
	logic        msg_valid_i = 1'b0;
	logic [15:0] msg_in = '0;                           // {pri, om, vecno, resv}
	logic        reg_we_i = 1'b0;
	logic        reg_re_i = 1'b0;
	logic [11:0] reg_addr_i = '0;
	logic [31:0] reg_wdata_i = '0;
	logic [31:0] reg_rdata_o;
	logic        reg_rvalid_o;
	logic        irq_o;
	logic [31:0] ivect_o;
	logic [2:0]  ipri_o;
	logic [2:0]  swstk_o;
	logic        irq_ack_i = 1'b0;

	// ============================================================
	// reference model state
	// ============================================================
	logic [15:0] mq [1:7][`MSI_QDEPTH];                 // per priority, head at 0
	int          mcnt [1:7];
	logic [31:0] tbl [1024];                            // what software wrote to the table
	logic        en_bits [1024];
	logic        m_gen = 1'b0;
	logic [2:0]  m_thr = 3'd0;
	logic        m_ovf = 1'b0;                          // expected sticky full flag
	int          n_grants = 0;                          // pops since reset, dropped ones too
	int          errors = 0;
	int          n_irq = 0;
	int          cycles = 0;
	logic        irq_prev = 1'b0;

	msi_top i_dut (
		.clk (clk), .rst (rst),
		.msg_valid_i (msg_valid_i), .msg_i (msg_in),
		.reg_we_i (reg_we_i), .reg_re_i (reg_re_i), .reg_addr_i (reg_addr_i),
		.reg_wdata_i (reg_wdata_i), .reg_rdata_o (reg_rdata_o), .reg_rvalid_o (reg_rvalid_o),
		.irq_o (irq_o), .ivect_o (ivect_o), .ipri_o (ipri_o), .swstk_o (swstk_o),
		.irq_ack_i (irq_ack_i)
	);

	always #4 clk = ~clk;

	// queue a message, priority 0 goes nowhere, a full queue drops it
	function automatic void model_push(input logic [15:0] m);
		int p;
		p = int'(m[15:13]);
		if (p != 0) begin
			if (mcnt[p] == `MSI_QDEPTH) begin
				m_ovf = 1'b1;
			end else begin
				mq[p][mcnt[p]] = m;
				mcnt[p]++;
			end
		end
	endfunction

	function automatic bit is_elig(input int p);
		return mcnt[p] > 0 && (p > int'(m_thr) || p == 7);  // 7 ignores the threshold
	endfunction

	// highest eligible queue, the lowest one on every eighth grant
	function automatic int pick_queue();
		int pick;
		bit fair;
		fair = (n_grants % `MSI_FAIR_PERIOD) == `MSI_FAIR_PERIOD - 1;
		pick = 0;
		for (int p = 7; p >= 1; p--)
			if (is_elig(p) && (pick == 0 || fair))
				pick = p;
		return pick;
	endfunction

	// next interrupt to expect; popped messages with any enable clear are dropped
	function automatic bit ref_next(output logic [31:0] ev, output logic [2:0] ep,
		output logic [2:0] es);
		int          p;
		bit          hit;
		logic [15:0] m;
		logic [31:0] ent;
		hit = 1'b0;
		ev = '0;
		ep = '0;
		es = '0;
		p = pick_queue();
		while (p != 0 && !hit) begin
			m = mq[p][0];
			for (int i = 1; i < mcnt[p]; i++)
				mq[p][i - 1] = mq[p][i];
			mcnt[p]--;
			n_grants++;
			ent = tbl[m[12:3]];                         // index is {om, vecno}
			if (ent[`MSI_ENT_IE] && m_gen && en_bits[m[12:3]]) begin
				hit = 1'b1;
				ev = {ent[`MSI_ENT_HND_HI:`MSI_ENT_HND_LO], 4'h0};
				ep = m[15:13];
				es = ent[`MSI_ENT_SWSTK_HI:`MSI_ENT_SWSTK_LO];
			end
			p = pick_queue();
		end
		return hit;
	endfunction

	// ============================================================
	// compare on each new irq_o, then take in this edge's message
	// ============================================================
	always @(posedge clk) begin
		logic [31:0] ev;
		logic [2:0]  ep;
		logic [2:0]  es;
		bit          hit;
		if (!rst) begin
			if (irq_o && !irq_prev) begin
				hit = ref_next(ev, ep, es);
				n_irq++;
				if (!hit) begin
					$display("error at %0t: interrupt raised with nothing deliverable", $time);
					errors++;
				end else begin
					if (ivect_o !== ev) begin
						$display("FAIL @%0t: ivect 0x%08h, expected 0x%08h", $time, ivect_o, ev);
						errors++;
					end
					if (ipri_o !== ep) begin
						$display("FAIL @%0t: ipri %0d, expected %0d", $time, ipri_o, ep);
						errors++;
					end
					if (swstk_o !== es) begin
						$display("FAIL @%0t: swstk %0d, expected %0d", $time, swstk_o, es);
						errors++;
					end
				end
			end
			if (msg_valid_i)
				model_push(msg_in);                     // too late for the pop just checked
		end
		irq_prev = irq_o;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > LIMIT_CYC) begin
			$display("timeout: test still running after %0d cycles", LIMIT_CYC);
			$display("errors %0d, interrupts %0d, grants %0d", errors + 1, n_irq, n_grants);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// ============================================================
	// register port and message tasks, all start on a falling edge
	// ============================================================
	task automatic reg_write(input logic [11:0] a, input logic [31:0] d);
		reg_we_i    = 1'b1;
		reg_addr_i  = a;
		reg_wdata_i = d;
		@(negedge clk);
		reg_we_i = 1'b0;
	endtask

	task automatic reg_read(input logic [11:0] a, output logic [31:0] d);
		reg_re_i   = 1'b1;
		reg_addr_i = a;
		@(negedge clk);
		reg_re_i = 1'b0;
		if (reg_rvalid_o !== 1'b1) begin
			$display("error at %0t: no read valid one cycle after the read strobe", $time);
			errors++;
		end
		d = reg_rdata_o;
		@(negedge clk);
		if (reg_rvalid_o !== 1'b0) begin
			$display("error at %0t: read valid stayed up a second cycle", $time);
			errors++;
		end
	endtask

	task automatic read_check(input logic [11:0] a, input logic [31:0] exp);
		logic [31:0] d;
		reg_read(a, d);
		if (d !== exp) begin
			$display("FAIL @%0t: reg 0x%03h read 0x%08h, expected 0x%08h", $time, a, d, exp);
			errors++;
		end
	endtask

	task automatic set_ctrl(input logic gen, input logic [2:0] thr);
		reg_write(`MSI_REG_CTRL, {28'd0, thr, gen});
		m_gen = gen;
		m_thr = thr;
	endtask

	task automatic set_entry(input logic [9:0] idx, input logic [31:0] v);
		reg_write(`MSI_REG_VT_BASE + 12'(idx), v);
		tbl[idx] = v;
	endtask

	task automatic set_en_word(input logic [4:0] w, input logic [31:0] v);
		reg_write(`MSI_REG_EN_BASE + 12'(w), v);
		for (int b = 0; b < 32; b++)
			en_bits[{w, 5'(b)}] = v[b];
	endtask

	task automatic send_msg(input logic [2:0] pri, input logic [9:0] idx);
		msg_valid_i = 1'b1;
		msg_in      = {pri, idx, 3'b000};
		@(negedge clk);
		msg_valid_i = 1'b0;
	endtask

	// returns on the falling edge where irq_o is seen high
	task automatic wait_irq(input int max_cyc, output bit seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < max_cyc) begin
			@(negedge clk);
			seen = irq_o;
			n++;
		end
	endtask

	task automatic ack_irq();
		irq_ack_i = 1'b1;
		@(negedge clk);
		irq_ack_i = 1'b0;
	endtask

	task automatic ack_all();
		bit seen;
		seen = 1'b1;
		while (seen) begin
			wait_irq(20, seen);
			if (seen)
				ack_irq();
		end
	endtask

	// no irq_o may come; the model then drops whatever the DUT discarded
	task automatic expect_quiet(input string what);
		bit          seen;
		bit          hit;
		logic [31:0] ev;
		logic [2:0]  ep;
		logic [2:0]  es;
		wait_irq(12, seen);
		if (seen) begin
			$display("error at %0t: interrupt raised after %s", $time, what);
			errors++;
			ack_irq();
		end
		hit = ref_next(ev, ep, es);
		if (hit) begin
			$display("error at %0t: vector 0x%08h never raised after %s", $time, ev, what);
			errors++;
		end
	endtask

	// hold one interrupt, queue a mixed burst behind it, then release one by one
	task automatic burst(input int n);
		bit seen;
		send_msg(3'd1, 10'($urandom % 1024));
		wait_irq(10, seen);
		if (!seen) begin
			$display("error at %0t: holding interrupt never came", $time);
			errors++;
		end
		for (int k = 0; k < n; k++)
			send_msg(3'(1 + $urandom % 7), 10'($urandom % 1024));
		ack_all();
		expect_quiet("a burst");
	endtask

	// ============================================================
	// stimulus
	// ============================================================
	initial begin
		logic [31:0] v;
		logic [31:0] d;
		bit          seen;
		int          base;
		void'($urandom(89));
		repeat (2) @(negedge clk);
		rst = 1'b0;

		for (int i = 0; i < 1024; i++) begin
			v = $urandom;
			v[`MSI_ENT_IE] = 1'b1;
			set_entry(10'(i), v);
		end
		for (int w = 0; w < 32; w++)
			set_en_word(5'(w), 32'hFFFF_FFFF);

		// register readback
		set_ctrl(1'b1, 3'd5);
		read_check(`MSI_REG_CTRL, 32'h0000_000B);   // threshold 5, enabled
		set_ctrl(1'b1, 3'd0);
		read_check(`MSI_REG_STAT, 32'h0000_00FE);   // all queues empty, no overflow
		v = $urandom;
		set_en_word(5'd9, v);
		read_check(`MSI_REG_EN_BASE + 12'd9, v);
		set_en_word(5'd9, 32'hFFFF_FFFF);
		for (int k = 0; k < 6; k++) begin
			base = int'($urandom % 1024);
			read_check(`MSI_REG_VT_BASE + 12'(base), tbl[base]);
		end

		// single message, irq_o after the third edge
		send_msg(3'd4, 10'h155);
		@(negedge clk);
		if (irq_o !== 1'b0) begin
			$display("FAIL @%0t: irq_o up one edge early", $time);
			errors++;
		end
		@(negedge clk);
		if (irq_o !== 1'b1) begin
			$display("FAIL @%0t: irq_o low three edges after the message", $time);
			errors++;
		end
		ack_irq();
		if (irq_o !== 1'b0) begin
			$display("FAIL @%0t: irq_o still high after the acknowledge", $time);
			errors++;
		end
		expect_quiet("the single message");

		burst(12);

		// threshold 4 holds back 2..4 until lowered, 7 goes through
		set_ctrl(1'b1, 3'd4);
		send_msg(3'd2, 10'($urandom % 1024));
		send_msg(3'd3, 10'($urandom % 1024));
		send_msg(3'd4, 10'($urandom % 1024));
		expect_quiet("priorities at or below the threshold");
		send_msg(3'd7, 10'($urandom % 1024));
		ack_all();
		set_ctrl(1'b1, 3'd0);
		ack_all();
		expect_quiet("lowering the threshold");

		// each of the three enables alone blocks delivery
		base = int'($urandom % 1024);
		set_en_word(5'(base >> 5), ~(32'd1 << (base % 32)));
		send_msg(3'd5, 10'(base));
		expect_quiet("a cleared enable bit");
		set_en_word(5'(base >> 5), 32'hFFFF_FFFF);
		v = tbl[base];
		v[`MSI_ENT_IE] = 1'b0;
		set_entry(10'(base), v);
		send_msg(3'd6, 10'(base));
		expect_quiet("a cleared entry enable");
		v[`MSI_ENT_IE] = 1'b1;
		set_entry(10'(base), v);
		set_ctrl(1'b0, 3'd0);
		send_msg(3'd7, 10'(base));
		expect_quiet("global enable off");
		set_ctrl(1'b1, 3'd0);

		burst(12);                                  // fair turns still counted from reset

		// ten messages into queue 3 behind a held interrupt
		send_msg(3'd7, 10'($urandom % 1024));
		wait_irq(10, seen);
		for (int k = 0; k < 10; k++)
			send_msg(3'd3, 10'($urandom % 1024));
		reg_read(`MSI_REG_STAT, d);
		if (d[0] !== 1'b1 || d[0] !== m_ovf) begin
			$display("FAIL @%0t: STAT bit 0 is %b after queue overflow", $time, d[0]);
			errors++;
		end
		base = n_irq;
		ack_all();
		if (n_irq - base != 8) begin
			$display("FAIL @%0t: %0d delivered from a full queue, expected 8", $time, n_irq - base);
			errors++;
		end
		expect_quiet("the overflow drain");
		send_msg(3'd0, 10'h3FF);
		expect_quiet("a priority 0 message");
		reg_write(`MSI_REG_STAT, 32'd0);
		m_ovf = 1'b0;
		read_check(`MSI_REG_STAT, 32'h0000_00FE);

		$display("errors %0d, interrupts %0d, grants %0d", errors, n_irq, n_grants);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+include
hdl/msi_pkg.sv
hdl/msi_fifo.sv
hdl/msi_prio_arb.sv
hdl/msi_vec_table.sv
hdl/msi_regs.sv
hdl/msi_dispatch.sv
hdl/msi_top.sv
verification/msi_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the MSI controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f sources.f --top-module msi_tb -Mdir obj_dir

./obj_dir/Vmsi_tb | tee sim.log

if grep -qF "=== PASS ===" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
